/* src/cpuTypesPkg.sv */
package cpuTypesPkg;

    localparam int SEQ_W = 7;
    localparam int TAG_W = 7;

    typedef logic [SEQ_W-1:0] SqN;
    typedef logic [TAG_W-1:0] Tag;

    typedef struct packed {
        logic valid;
        logic isLoad;
        logic isStore;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        SqN sqN;
        SqN loadSqN;
        Tag tagDst;
        logic [31:0] pc;
        logic compressed;
    } AguUop;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        SqN sqN;
        SqN loadSqN;
        Tag tagDst;
        logic isMmio;
    } LoadUop;

    typedef struct packed {
        logic taken;
        SqN sqN;
        SqN loadSqN;
        logic [31:0] dstPc;
    } BranchProv;

    // Sequence numbers wrap, so age is decided by the sign of the difference
    function automatic logic isOlder(SqN a, SqN b);
        logic signed [SEQ_W-1:0] diff;
        diff = a - b;
        return diff < 0;
    endfunction

    // An op survives a rollback unless it is younger than the branch
    function automatic logic isLive(AguUop u, BranchProv br);
        return u.valid && (!br.taken || !isOlder(br.sqN, u.sqN));
    endfunction

endpackage

/* src/loadBufPkg.sv */
package loadBufPkg;

    import cpuTypesPkg::*;

    localparam int LB_SIZE = 8;
    localparam int LB_IDX_W = 3;
    localparam int LB_TAG_W = SEQ_W - LB_IDX_W;
    localparam int NUM_PORTS = 2;
    localparam logic [3:0] MMIO_NIBBLE = 4'hF;

    typedef logic [LB_IDX_W-1:0] LbIdx;

    typedef struct packed {
        logic valid;
        logic issued;
        logic nonSpec;
        logic [LB_TAG_W-1:0] highLdSqN;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        SqN sqN;
        Tag tagDst;
    } LbEntry;

    typedef struct packed {
        logic valid;
        LbIdx idx;
    } LateIssue;

    // Bytes of a word touched by an access of the given size at the given offset
    function automatic logic [3:0] byteMask(logic [1:0] size, logic [1:0] low);
        case (size)
            2'd0: return 4'b0001 << low;
            2'd1: return low[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic bytesOverlap(logic [1:0] sizeA, logic [1:0] lowA,
                                          logic [1:0] sizeB, logic [1:0] lowB);
        return |(byteMask(sizeA, lowA) & byteMask(sizeB, lowB));
    endfunction

endpackage

/* src/loadEntryTable.sv */
`timescale 1ns/1ps

module loadEntryTable
    import cpuTypesPkg::*;
    import loadBufPkg::*;
(
    input logic clk,
    input logic rst,

    input AguUop uop[NUM_PORTS-1:0],
    input logic [NUM_PORTS-1:0] insNonSpec,
    input SqN comLoadSqN,
    input BranchProv branch,
    input LateIssue lateIssue,

    output LbEntry entries[LB_SIZE-1:0],
    output SqN maxLoadSqN
);

    SqN lastComLoadSqN;
    SqN releaseDist;
    LbIdx releaseBase;
    logic [LB_SIZE-1:0] releaseMask;
    logic [LB_SIZE-1:0] rollbackMask;
    logic [LB_SIZE-1:0] invalMask;
    logic [NUM_PORTS-1:0] insert;

    assign releaseDist = comLoadSqN - lastComLoadSqN;
    assign releaseBase = lastComLoadSqN[LB_IDX_W-1:0];

    // Committed loads form a window that starts at last cycle's head and may wrap
    always_comb begin
        for (int i = 0; i < LB_SIZE; i++) begin
            LbIdx offset;
            offset = LbIdx'(i) - releaseBase;
            releaseMask[i] = SqN'(offset) < releaseDist;
        end
    end

    always_comb begin
        for (int i = 0; i < LB_SIZE; i++) begin
            rollbackMask[i] = branch.taken &&
                !isOlder({entries[i].highLdSqN, LbIdx'(i)}, branch.loadSqN);
        end
    end

    assign invalMask = releaseMask | rollbackMask;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            insert[p] = isLive(uop[p], branch) && uop[p].isLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].issued <= 1'b0;
                entries[i].nonSpec <= 1'b0;
            end
        end else begin
            for (int i = 0; i < LB_SIZE; i++) begin
                if (invalMask[i]) begin
                    entries[i].valid <= 1'b0;
                    entries[i].issued <= 1'b0;
                end
            end

            if (lateIssue.valid) begin
                entries[lateIssue.idx].issued <= 1'b1;
            end

            // New loads land in the slot named by their load sequence number
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (insert[p]) begin
                    LbIdx idx;
                    idx = uop[p].loadSqN[LB_IDX_W-1:0];
                    entries[idx].valid <= 1'b1;
                    entries[idx].issued <= !insNonSpec[p];
                    entries[idx].nonSpec <= insNonSpec[p];
                    entries[idx].highLdSqN <= uop[p].loadSqN[SEQ_W-1:LB_IDX_W];
                    entries[idx].addr <= uop[p].addr;
                    entries[idx].size <= uop[p].size;
                    entries[idx].signExtend <= uop[p].signExtend;
                    entries[idx].sqN <= uop[p].sqN;
                    entries[idx].tagDst <= uop[p].tagDst;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lastComLoadSqN <= comLoadSqN;
        maxLoadSqN <= comLoadSqN + SqN'(LB_SIZE - 1);
    end

endmodule

/* src/orderViolationCheck.sv */
`timescale 1ns/1ps

module orderViolationCheck
    import cpuTypesPkg::*;
    import loadBufPkg::*;
(
    input AguUop uop[NUM_PORTS-1:0],
    input LbEntry entries[LB_SIZE-1:0],
    input BranchProv branch,

    output BranchProv flush
);

    logic [LB_SIZE-1:0] hit[NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] storeLive;
    logic [NUM_PORTS-1:0] conflict;

    // A store conflicts with any issued load that is younger and read one of its bytes
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            storeLive[p] = isLive(uop[p], branch) && uop[p].isStore;
            for (int i = 0; i < LB_SIZE; i++) begin
                hit[p][i] = entries[i].valid && entries[i].issued &&
                    entries[i].addr[31:2] == uop[p].addr[31:2] &&
                    bytesOverlap(entries[i].size, entries[i].addr[1:0],
                                 uop[p].size, uop[p].addr[1:0]) &&
                    !isOlder({entries[i].highLdSqN, LbIdx'(i)}, uop[p].loadSqN);
            end
            conflict[p] = storeLive[p] && |hit[p];
        end
    end

    // Restart right after the oldest conflicting store
    always_comb begin
        flush = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (conflict[p] && (!flush.taken || isOlder(uop[p].sqN, flush.sqN))) begin
                flush.taken = 1'b1;
                flush.sqN = uop[p].sqN;
                flush.loadSqN = uop[p].loadSqN;
                flush.dstPc = uop[p].pc + (uop[p].compressed ? 32'd2 : 32'd4);
            end
        end
    end

endmodule

/* src/mmioLoadIssue.sv */
`timescale 1ns/1ps

module mmioLoadIssue
    import cpuTypesPkg::*;
    import loadBufPkg::*;
(
    input logic clk,
    input logic rst,

    input AguUop uop[NUM_PORTS-1:0],
    input LbEntry entries[LB_SIZE-1:0],
    input SqN comSqN,
    input SqN comLoadSqN,
    input logic sqDone,
    input BranchProv branch,
    input logic stall,

    output LoadUop uopAguLd[NUM_PORTS-1:0],
    output logic [NUM_PORTS-1:0] insNonSpec,
    output LateIssue lateIssue,
    output LoadUop uopLd
);

    logic [NUM_PORTS-1:0] isMmio;
    LbIdx headIdx;
    LbEntry head;
    logic grant;
    logic dropLd;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            isMmio[p] = uop[p].addr[31:28] == MMIO_NIBBLE;
            insNonSpec[p] = uop[p].isLoad && isMmio[p];
            uopAguLd[p] = LoadUop'{
                valid: isLive(uop[p], branch) && uop[p].isLoad && !isMmio[p],
                addr: uop[p].addr,
                size: uop[p].size,
                signExtend: uop[p].signExtend,
                sqN: uop[p].sqN,
                loadSqN: uop[p].loadSqN,
                tagDst: uop[p].tagDst,
                isMmio: 1'b0
            };
        end
    end

    // MMIO loads go out only once they are the next instruction to commit
    assign headIdx = comLoadSqN[LB_IDX_W-1:0];
    assign head = entries[headIdx];
    assign grant = head.valid && !head.issued && head.nonSpec &&
        head.sqN == comSqN && sqDone && !branch.taken && !uopLd.valid;

    assign lateIssue = LateIssue'{valid: grant, idx: headIdx};

    assign dropLd = !stall || (branch.taken && isOlder(branch.sqN, uopLd.sqN));

    always_ff @(posedge clk) begin
        if (rst) begin
            uopLd.valid <= 1'b0;
        end else if (grant) begin
            uopLd <= LoadUop'{
                valid: 1'b1,
                addr: head.addr,
                size: head.size,
                signExtend: head.signExtend,
                sqN: head.sqN,
                loadSqN: {head.highLdSqN, headIdx},
                tagDst: head.tagDst,
                isMmio: 1'b1
            };
        end else if (uopLd.valid && dropLd) begin
            uopLd.valid <= 1'b0;
        end
    end

endmodule

/* src/loadBuffer.sv */
`timescale 1ns/1ps

module loadBuffer
    import cpuTypesPkg::*;
(
    input logic clk,
    input logic rst,

    input AguUop uop[loadBufPkg::NUM_PORTS-1:0],
    input SqN comSqN,
    input SqN comLoadSqN,
    input logic sqDone,
    input BranchProv branch,
    input logic stall,

    output LoadUop uopAguLd[loadBufPkg::NUM_PORTS-1:0],
    output LoadUop uopLd,
    output BranchProv flush,
    output SqN maxLoadSqN
);

    loadBufPkg::LbEntry entries[loadBufPkg::LB_SIZE-1:0];
    logic [loadBufPkg::NUM_PORTS-1:0] insNonSpec;
    loadBufPkg::LateIssue lateIssue;

    loadEntryTable table0 (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .insNonSpec(insNonSpec),
        .comLoadSqN(comLoadSqN),
        .branch(branch),
        .lateIssue(lateIssue),
        .entries(entries),
        .maxLoadSqN(maxLoadSqN)
    );

    orderViolationCheck violation0 (
        .uop(uop),
        .entries(entries),
        .branch(branch),
        .flush(flush)
    );

    mmioLoadIssue issue0 (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .entries(entries),
        .comSqN(comSqN),
        .comLoadSqN(comLoadSqN),
        .sqDone(sqDone),
        .branch(branch),
        .stall(stall),
        .uopAguLd(uopAguLd),
        .insNonSpec(insNonSpec),
        .lateIssue(lateIssue),
        .uopLd(uopLd)
    );

endmodule

/* tests/loadBuffer_assert.sv */
`timescale 1ns/1ps

module loadBufferAssert
    import cpuTypesPkg::*;
    import loadBufPkg::*;
(
    input logic clk,
    input logic rst,
    input AguUop uop[NUM_PORTS-1:0],
    input BranchProv branch,
    input logic stall,
    input LoadUop uopAguLd[NUM_PORTS-1:0],
    input LoadUop uopLd,
    input BranchProv flush
);

    int failCount = 0;
    logic storePresent;

    assign storePresent = (uop[0].valid && uop[0].isStore) || (uop[1].valid && uop[1].isStore);

    flushNeedsStore: assert property (@(posedge clk) disable iff (rst)
        flush.taken |-> storePresent)
        else begin
            failCount++;
            $error("flush raised while no store is presented");
        end

    // A stalled late load may only change when a rollback removes it
    lateLoadHeld: assert property (@(posedge clk) disable iff (rst)
        uopLd.valid && stall && !branch.taken |=> $stable(uopLd))
        else begin
            failCount++;
            $error("uopLd changed while stalled");
        end

    lateLoadIsMmio: assert property (@(posedge clk) disable iff (rst)
        uopLd.valid |-> uopLd.isMmio)
        else begin
            failCount++;
            $error("uopLd valid without isMmio");
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : perPort
        earlyNotMmio: assert property (@(posedge clk) disable iff (rst)
            uopAguLd[p].valid |-> uopAguLd[p].addr[31:28] != MMIO_NIBBLE)
            else begin
                failCount++;
                $error("uopAguLd carries an MMIO address");
            end
    end

endmodule

bind loadBuffer loadBufferAssert asserts (
    .clk(clk),
    .rst(rst),
    .uop(uop),
    .branch(branch),
    .stall(stall),
    .uopAguLd(uopAguLd),
    .uopLd(uopLd),
    .flush(flush)
);

/* tests/loadBufferTb.sv */
`timescale 1ns/1ps

module loadBufferTb
    import cpuTypesPkg::*;
    import loadBufPkg::*;
();

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES = 4000;
    localparam int MARGIN = 100;

    logic clk;
    logic rst;
    AguUop uop[NUM_PORTS-1:0];
    SqN comSqN;
    SqN comLoadSqN;
    logic sqDone;
    BranchProv branch;
    logic stall;
    LoadUop uopAguLd[NUM_PORTS-1:0];
    LoadUop uopLd;
    BranchProv flush;
    SqN maxLoadSqN;

    // Shadow of the buffer state as seen after the last rising edge
    LbEntry shadow[LB_SIZE];
    LoadUop expLd;
    SqN expMax;
    SqN lastCom;
    SqN nextSqN;
    SqN nextLdSqN;
    int flushCount;
    int lateCount;

    loadBuffer dut (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .comSqN(comSqN),
        .comLoadSqN(comLoadSqN),
        .sqDone(sqDone),
        .branch(branch),
        .stall(stall),
        .uopAguLd(uopAguLd),
        .uopLd(uopLd),
        .flush(flush),
        .maxLoadSqN(maxLoadSqN)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Negative wrapped difference means a was allocated before b
    function automatic logic olderThan(SqN a, SqN b);
        SqN d;
        d = a - b;
        return d[SEQ_W-1];
    endfunction

    function automatic logic liveOp(AguUop u, BranchProv br);
        return u.valid && !(br.taken && olderThan(br.sqN, u.sqN));
    endfunction

    function automatic logic mmioAddr(logic [31:0] a);
        return a[31:28] == MMIO_NIBBLE;
    endfunction

    function automatic logic [3:0] touched(logic [1:0] size, logic [1:0] low);
        logic [3:0] m;
        m = (size == 2'd0) ? 4'b0001 : ((size == 2'd1) ? 4'b0011 : 4'b1111);
        return m << low;
    endfunction

    function automatic BranchProv predictFlush();
        BranchProv f;
        logic hit;
        f = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            hit = 1'b0;
            for (int i = 0; i < LB_SIZE; i++) begin
                if (shadow[i].valid && shadow[i].issued &&
                    shadow[i].addr[31:2] == uop[p].addr[31:2] &&
                    |(touched(shadow[i].size, shadow[i].addr[1:0]) &
                      touched(uop[p].size, uop[p].addr[1:0])) &&
                    !olderThan({shadow[i].highLdSqN, LbIdx'(i)}, uop[p].loadSqN)) begin
                    hit = 1'b1;
                end
            end
            if (liveOp(uop[p], branch) && uop[p].isStore && hit &&
                (!f.taken || olderThan(uop[p].sqN, f.sqN))) begin
                f.taken = 1'b1;
                f.sqN = uop[p].sqN;
                f.loadSqN = uop[p].loadSqN;
                f.dstPc = uop[p].pc + (uop[p].compressed ? 32'd2 : 32'd4);
            end
        end
        return f;
    endfunction

    function automatic LoadUop earlyLoadFor(int p);
        LoadUop l;
        l.valid = liveOp(uop[p], branch) && uop[p].isLoad && !mmioAddr(uop[p].addr);
        l.addr = uop[p].addr;
        l.size = uop[p].size;
        l.signExtend = uop[p].signExtend;
        l.sqN = uop[p].sqN;
        l.loadSqN = uop[p].loadSqN;
        l.tagDst = uop[p].tagDst;
        l.isMmio = 1'b0;
        return l;
    endfunction

    task automatic expectEqual(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    always @(posedge clk) begin : modelStep
        LbIdx idx;
        LbIdx headIdx;
        LbEntry head;
        logic grant;
        SqN span;
        if (rst) begin
            for (int i = 0; i < LB_SIZE; i++) begin
                shadow[i] = '0;
            end
            expLd = '0;
        end else begin
            headIdx = comLoadSqN[LB_IDX_W-1:0];
            head = shadow[headIdx];
            grant = head.valid && !head.issued && head.nonSpec && head.sqN == comSqN &&
                sqDone && !branch.taken && !expLd.valid;
            if (grant) begin
                expLd = '{valid: 1'b1, addr: head.addr, size: head.size,
                          signExtend: head.signExtend, sqN: head.sqN,
                          loadSqN: {head.highLdSqN, headIdx}, tagDst: head.tagDst,
                          isMmio: 1'b1};
                lateCount++;
            end else if (expLd.valid &&
                         (!stall || (branch.taken && olderThan(branch.sqN, expLd.sqN)))) begin
                expLd.valid = 1'b0;
            end
            // Loads committed since the last edge leave the table
            span = comLoadSqN - lastCom;
            for (int k = 0; k < LB_SIZE && k < int'(span); k++) begin
                idx = LbIdx'(lastCom + SqN'(k));
                shadow[idx].valid = 1'b0;
                shadow[idx].issued = 1'b0;
            end
            if (branch.taken) begin
                for (int i = 0; i < LB_SIZE; i++) begin
                    if (!olderThan({shadow[i].highLdSqN, LbIdx'(i)}, branch.loadSqN)) begin
                        shadow[i].valid = 1'b0;
                        shadow[i].issued = 1'b0;
                    end
                end
            end
            if (grant) begin
                shadow[headIdx].issued = 1'b1;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (liveOp(uop[p], branch) && uop[p].isLoad) begin
                    idx = uop[p].loadSqN[LB_IDX_W-1:0];
                    shadow[idx] = '{valid: 1'b1, issued: !mmioAddr(uop[p].addr),
                                    nonSpec: mmioAddr(uop[p].addr),
                                    highLdSqN: uop[p].loadSqN[SEQ_W-1:LB_IDX_W],
                                    addr: uop[p].addr, size: uop[p].size,
                                    signExtend: uop[p].signExtend, sqN: uop[p].sqN,
                                    tagDst: uop[p].tagDst};
                end
            end
        end
        lastCom = comLoadSqN;
        expMax = SqN'((int'(comLoadSqN) + LB_SIZE - 1) % (1 << SEQ_W));
    end

    task automatic driveCycle();
        LbEntry head;
        SqN inFlight;
        SqN sqBefore;
        int kind;
        logic [1:0] size;
        logic [1:0] low;
        logic [3:0] nib;
        // An MMIO load at the head blocks commit until it has gone out
        head = shadow[comLoadSqN[LB_IDX_W-1:0]];
        inFlight = nextLdSqN - comLoadSqN;
        if (inFlight != 0 && !(head.valid && head.nonSpec && !head.issued) &&
            $urandom_range(2) == 0) begin
            comLoadSqN = comLoadSqN + SqN'(1);
            inFlight = inFlight - SqN'(1);
        end
        head = shadow[comLoadSqN[LB_IDX_W-1:0]];
        comSqN = (head.valid && $urandom_range(3) != 0) ? head.sqN : SqN'($urandom);
        sqDone = $urandom_range(3) != 0;
        stall = $urandom_range(1);
        sqBefore = nextSqN;
        for (int p = 0; p < NUM_PORTS; p++) begin
            kind = $urandom_range(3);
            uop[p] = '0;
            if (kind == 3 || (kind != 0 && SqN'(nextLdSqN - comLoadSqN) < SqN'(LB_SIZE))) begin
                size = 2'($urandom_range(2));
                low = 2'($urandom_range(3));
                if (size == 2'd1) low[0] = 1'b0;
                if (size == 2'd2) low = 2'd0;
                nib = ($urandom_range(4) == 0) ? MMIO_NIBBLE : 4'h8;
                uop[p].valid = 1'b1;
                uop[p].isLoad = kind < 3;
                uop[p].isStore = kind == 3;
                uop[p].addr = {nib, 22'h0, 4'($urandom_range(3)), low};
                uop[p].size = size;
                uop[p].signExtend = $urandom_range(1);
                uop[p].sqN = nextSqN;
                uop[p].tagDst = Tag'($urandom);
                uop[p].pc = $urandom & 32'hffff_fffe;
                uop[p].compressed = $urandom_range(1);
                nextSqN = nextSqN + SqN'(1);
                if (kind < 3) begin
                    uop[p].loadSqN = nextLdSqN;
                    nextLdSqN = nextLdSqN + SqN'(1);
                end else begin
                    uop[p].loadSqN = comLoadSqN + SqN'($urandom_range(inFlight));
                end
            end
        end
        // A rollback older than every op of this cycle kills them all
        branch = '0;
        if ($urandom_range(23) == 0) begin
            branch.taken = 1'b1;
            branch.sqN = sqBefore - SqN'($urandom_range(3, 1));
            branch.loadSqN = comLoadSqN + SqN'($urandom_range(inFlight));
            branch.dstPc = $urandom;
            nextSqN = branch.sqN + SqN'(1);
            nextLdSqN = branch.loadSqN;
        end
    endtask

    initial begin : compare
        BranchProv f;
        LoadUop e;
        forever begin
            @(negedge clk);
            #1;
            if (!rst) begin
                f = predictFlush();
                if (f.taken) flushCount++;
                expectEqual("flush", flush, f);
                for (int p = 0; p < NUM_PORTS; p++) begin
                    e = earlyLoadFor(p);
                    expectEqual($sformatf("uopAguLd[%0d].valid", p), uopAguLd[p].valid, e.valid);
                    if (e.valid) expectEqual($sformatf("uopAguLd[%0d]", p), uopAguLd[p], e);
                end
                expectEqual("uopLd.valid", uopLd.valid, expLd.valid);
                if (expLd.valid) expectEqual("uopLd", uopLd, expLd);
                expectEqual("maxLoadSqN", maxLoadSqN, expMax);
            end
        end
    end

    initial begin : assertWatch
        wait (dut.asserts.failCount != 0);
        $display("A bound assertion failed at %0t ns", $time);
        $display("Testbench failed");
        $fatal(1, "assertion failure");
    end

    initial begin : stimulus
        void'($urandom(32'hc306_77c0));
        rst = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            uop[p] = '0;
        end
        comSqN = '0;
        comLoadSqN = '0;
        sqDone = 1'b0;
        branch = '0;
        stall = 1'b0;
        nextSqN = '0;
        nextLdSqN = '0;
        flushCount = 0;
        lateCount = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (TEST_CYCLES) begin
            driveCycle();
            @(negedge clk);
        end
        #2;
        $display("%0d flushes and %0d late issues seen", flushCount, lateCount);
        if (flushCount == 0 || lateCount == 0) begin
            $display("The random stimulus never raised a flush or a late MMIO issue");
            $display("Testbench failed");
            $fatal(1, "behaviors not reached");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + TEST_CYCLES + 2) * PERIOD + MARGIN);
        $display("Simulation ran past its time limit without finishing");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

endmodule

/* tb.f */
src/cpuTypesPkg.sv
src/loadBufPkg.sv
src/loadEntryTable.sv
src/orderViolationCheck.sv
src/mmioLoadIssue.sv
src/loadBuffer.sv
tests/loadBuffer_assert.sv
tests/loadBufferTb.sv

/* Bender.yml */
package:
  name: load_buffer

sources:
  - files:
      - src/cpuTypesPkg.sv
      - src/loadBufPkg.sv
      - src/loadEntryTable.sv
      - src/orderViolationCheck.sv
      - src/mmioLoadIssue.sv
      - src/loadBuffer.sv
  - target: test
    files:
      - tests/loadBuffer_assert.sv
      - tests/loadBufferTb.sv
